// ==== build.f ====
logic/lsu_mem_pkg.sv
logic/lsu_op_pkg.sv
logic/lsu_store_align.sv
logic/lsu_load_align.sv
logic/lsu_ctrl.sv
logic/lsu_top.sv
bench/lsu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = lsu_tb
FILELIST  = build.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== bench/lsu_tb.sv ====
// testbench for the load/store unit
// clock, reset, data memory model with random grant and response delays
// random aligned stimulus, reference model, checker and timeout

`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  localparam int          N_RANDOM   = 200;                        // mixed random accesses
  localparam int          N_WORDS    = 16;                         // model depth
  localparam int          MAX_CYCLES = (N_RANDOM + N_WORDS) * 10;  // 10 cycles per access
  localparam logic [31:0] SEED       = 32'hc2865680;

  logic               clk;
  logic               rst_n;
  logic               data_req_ex_i, data_we_ex_i, data_sign_ext_ex_i;
  lsu_op_pkg::size_t  data_type_ex_i;
  lsu_mem_pkg::addr_t adder_result_ex_i, data_addr_o;
  lsu_mem_pkg::word_t data_wdata_ex_i, data_rdata_ex_o, data_wdata_o, data_rdata_i;
  logic               lsu_ready_ex_o, lsu_ready_wb_o, data_valid_o, busy_o;
  logic               data_req_o, data_we_o, data_gnt_i, data_rvalid_i;
  lsu_mem_pkg::be_t   data_be_o;

  lsu_mem_pkg::word_t mem [N_WORDS];      // model array written through the DUT enables
  lsu_mem_pkg::word_t ref_mem [N_WORDS];  // shadow array written from the reference
  int                 cycles;
  logic               outstanding;        // accepted and response not back yet
  logic               acc_we, acc_sign;   // attributes of the accepted access
  lsu_op_pkg::size_t  acc_type;
  lsu_mem_pkg::lane_t acc_lane;
  logic [3:0]         acc_idx;
  lsu_mem_pkg::word_t hold_exp;           // last load result
  logic [67:0]        exp_acc;            // {be, write word, load value}

  lsu_top i_lsu_top (.*);

  ////////////////////////////////////////
  // helpers and reference
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // power-up contents distinct for every word address
  function automatic lsu_mem_pkg::word_t fill_word(input int idx);
    return 32'h9e3779b9 * (idx + 1) ^ {idx[7:0], 24'h5a0f3c};
  endfunction

  // expected enables, rotated write word and extended load for one access
  function automatic logic [67:0] ref_access(input lsu_op_pkg::size_t size,
                                             input lsu_mem_pkg::lane_t lane, input logic sign,
                                             input lsu_mem_pkg::word_t wdata,
                                             input lsu_mem_pkg::word_t mword);
    int          nbytes;
    logic [3:0]  be;
    logic [63:0] rot;
    logic [31:0] sh;
    logic [31:0] ld;
    nbytes = (size == lsu_op_pkg::SIZE_WORD) ? 4 : (size == lsu_op_pkg::SIZE_HALF) ? 2 : 1;
    for (int i = 0; i < 4; i++)
    begin
      be[i] = (i >= int'(lane)) && (i < int'(lane) + nbytes);  // lanes the access covers
    end
    rot = {wdata, wdata} << (8 * lane);  // upper half is the rotated word
    sh  = mword >> (8 * lane);           // addressed byte down to [7:0]
    case (nbytes)
      4:       ld = mword;
      2:       ld = {{16{sign & sh[15]}}, sh[15:0]};
      default: ld = {{24{sign & sh[7]}}, sh[7:0]};
    endcase
    return {be, rot[63:32], ld};
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want)
      fail_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, what, got, want));
  endtask

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial
  begin
    logic [31:0]        drv_seed;
    logic [31:0]        r;
    lsu_op_pkg::size_t  sz;
    lsu_mem_pkg::lane_t ln;
    logic [3:0]         idx;
    rst_n              = 1'b0;
    data_req_ex_i      = 1'b0;
    data_we_ex_i       = 1'b0;
    data_type_ex_i     = lsu_op_pkg::SIZE_WORD;
    data_sign_ext_ex_i = 1'b0;
    adder_result_ex_i  = '0;
    data_wdata_ex_i    = '0;
    drv_seed           = SEED;
    repeat (3) @(posedge clk);
    check_value("outputs in reset", 32'({data_req_o, lsu_ready_ex_o, data_valid_o, busy_o}), 0);
    check_value("load result in reset", data_rdata_ex_o, 32'd0);
    rst_n <= 1'b1;
    // random traffic followed by a word readback of the whole array
    for (int n = 0; n < N_RANDOM + N_WORDS; n++)
    begin
      drv_seed = lcg_next(drv_seed);
      r        = drv_seed;
      sz  = (n < N_RANDOM) ? r[30:29] : lsu_op_pkg::SIZE_WORD;
      ln  = (sz == lsu_op_pkg::SIZE_WORD) ? 2'b00 :
            (sz == lsu_op_pkg::SIZE_HALF) ? {r[28], 1'b0} : r[28:27];  // aligned only
      idx = (n < N_RANDOM) ? r[26:23] : 4'(n - N_RANDOM);
      drv_seed = lcg_next(drv_seed);
      if (r[21])
        @(posedge clk);  // idle gap
      data_req_ex_i      <= 1'b1;
      data_we_ex_i       <= (n < N_RANDOM) ? r[31] : 1'b0;
      data_type_ex_i     <= sz;
      data_sign_ext_ex_i <= r[22];
      adder_result_ex_i  <= {r[20:0], 5'b00000, idx, ln};
      data_wdata_ex_i    <= drv_seed;
      do @(posedge clk); while (!lsu_ready_ex_o);  // held until the grant
      data_req_ex_i <= 1'b0;
      do @(posedge clk); while (!data_valid_o);
    end
    @(posedge clk);
    for (int i = 0; i < N_WORDS; i++)
      check_value($sformatf("model word %0d", i), mem[i], ref_mem[i]);
    $display("SIMULATION PASSED");
    $finish;
  end

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  // grant 0..3 cycles after the request and rvalid 1..3 cycles after acceptance
  initial
  begin
    logic [31:0] mem_seed;
    int          gnt_wait;
    int          rsp_wait;
    logic        rsp_pend;
    logic [3:0]  rsp_idx;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    mem_seed      = SEED ^ 32'h3c3c3c3c;  // separate stream from the driver
    gnt_wait      = 0;
    rsp_wait      = 0;
    rsp_pend      = 1'b0;
    rsp_idx       = '0;
    for (int i = 0; i < N_WORDS; i++)
      mem[i] = fill_word(i);
    forever
    begin
      @(posedge clk);
      data_rvalid_i <= 1'b0;
      if (data_req_o && data_gnt_i)
      begin
        rsp_idx = data_addr_o[5:2];
        for (int b = 0; b < 4; b++)
          if (data_we_o && data_be_o[b])
            mem[rsp_idx][8*b +: 8] = data_wdata_o[8*b +: 8];  // enabled lanes only
        mem_seed   = lcg_next(mem_seed);
        gnt_wait   = int'(mem_seed[31:30]);      // for the next request
        rsp_wait   = int'(mem_seed[29:28]) % 3;
        rsp_pend   = 1'b1;
        data_gnt_i <= 1'b0;
      end
      else if (data_req_o)
      begin
        if (gnt_wait <= 1)
          data_gnt_i <= 1'b1;
        else
          gnt_wait--;  // back-pressure
      end
      if (rsp_pend && rsp_wait == 0)
      begin
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= mem[rsp_idx];
        data_gnt_i    <= (gnt_wait == 0);  // with no wait the grant is up before the request
        rsp_pend = 1'b0;
      end
      else if (rsp_pend)
        rsp_wait--;
    end
  end

  ////////////////////////////////////////
  // checker and timeout
  ////////////////////////////////////////

  initial
  begin
    cycles      = 0;
    outstanding = 1'b0;
    hold_exp    = '0;
    for (int i = 0; i < N_WORDS; i++)
      ref_mem[i] = fill_word(i);
    forever
    begin
      @(posedge clk);
      cycles++;
      if (cycles >= MAX_CYCLES)
        fail_run($sformatf("timeout, the test did not finish within %0d cycles", cycles));
      if (rst_n)
      begin
        // bus handshake derived from the stimulus and the outstanding flag
        check_value("req/ready/valid/busy/ready_wb",
                    32'({data_req_o, lsu_ready_ex_o, data_valid_o, busy_o, lsu_ready_wb_o}),
                    32'({data_req_ex_i && !outstanding, data_req_ex_i && !outstanding &&
                         data_gnt_i, outstanding && data_rvalid_i,
                         data_req_ex_i || outstanding, 1'b0}));
        if (outstanding && data_rvalid_i)
        begin
          outstanding = 1'b0;
          exp_acc = ref_access(acc_type, acc_lane, acc_sign, '0, ref_mem[acc_idx]);
          if (!acc_we)
            hold_exp = exp_acc[31:0];  // stores keep the old result
        end
        check_value("data_rdata_ex_o", data_rdata_ex_o, hold_exp);
        if (data_req_ex_i && !outstanding && data_gnt_i)  // accepting cycle
        begin
          acc_we   = data_we_ex_i;
          acc_type = data_type_ex_i;
          acc_lane = adder_result_ex_i[1:0];
          acc_sign = data_sign_ext_ex_i;
          acc_idx  = adder_result_ex_i[5:2];
          exp_acc  = ref_access(acc_type, acc_lane, acc_sign, data_wdata_ex_i, 32'd0);
          check_value("data_addr_o", data_addr_o, adder_result_ex_i);
          check_value("data_we_o", 32'(data_we_o), 32'(acc_we));
          check_value("data_be_o", 32'(data_be_o), 32'(exp_acc[67:64]));
          if (acc_we)
          begin
            check_value("data_wdata_o", data_wdata_o, exp_acc[63:32]);
            for (int b = 0; b < 4; b++)
              if (exp_acc[64 + b])
                ref_mem[acc_idx][8*b +: 8] = exp_acc[32 + 8*b +: 8];
          end
          outstanding = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/lsu_top.sv ====
// load/store unit top level
// execute-stage and data-memory ports
// store alignment, load alignment and bus controller instances

`timescale 1ns/1ps
`default_nettype none

module lsu_top
(
  input  logic               clk,
  input  logic               rst_n,

  // execute stage
  input  logic               data_req_ex_i,       // level, held until ready
  input  logic               data_we_ex_i,
  input  lsu_op_pkg::size_t  data_type_ex_i,
  input  logic               data_sign_ext_ex_i,
  input  lsu_mem_pkg::addr_t adder_result_ex_i,   // effective address
  input  lsu_mem_pkg::word_t data_wdata_ex_i,
  output logic               lsu_ready_ex_o,
  output logic               lsu_ready_wb_o,
  output logic               data_valid_o,
  output lsu_mem_pkg::word_t data_rdata_ex_o,
  output logic               busy_o,

  // data memory
  output logic               data_req_o,
  output lsu_mem_pkg::addr_t data_addr_o,
  output logic               data_we_o,
  output lsu_mem_pkg::be_t   data_be_o,
  output lsu_mem_pkg::word_t data_wdata_o,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  lsu_mem_pkg::word_t data_rdata_i
);

  lsu_mem_pkg::lane_t lane;

  assign lane           = adder_result_ex_i[1:0];  // byte offset in the word
  assign data_addr_o    = adder_result_ex_i;       // full address, lanes via be
  assign data_we_o      = data_we_ex_i;
  assign lsu_ready_wb_o = 1'b0;                    // no WB-side stall from here

  lsu_store_align i_store_align (
    .clk         (clk),
    .req_i       (data_req_o),
    .data_type_i (data_type_ex_i),
    .lane_i      (lane),
    .wdata_i     (data_wdata_ex_i),
    .be_o        (data_be_o),
    .wdata_o     (data_wdata_o)
  );

  lsu_load_align i_load_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .gnt_i       (data_gnt_i),
    .rvalid_i    (data_rvalid_i),
    .we_i        (data_we_ex_i),
    .data_type_i (data_type_ex_i),
    .sign_ext_i  (data_sign_ext_ex_i),
    .lane_i      (lane),
    .rdata_i     (data_rdata_i),
    .rdata_o     (data_rdata_ex_o)
  );

  lsu_ctrl i_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_ex_i    (data_req_ex_i),
    .gnt_i       (data_gnt_i),
    .rvalid_i    (data_rvalid_i),
    .addr_i      (adder_result_ex_i),
    .data_req_o  (data_req_o),
    .ready_ex_o  (lsu_ready_ex_o),
    .valid_o     (data_valid_o),
    .busy_o      (busy_o)
  );

endmodule

`default_nettype wire

// ==== logic/lsu_ctrl.sv ====
// request/grant/rvalid controller
// three-state FSM, one transfer outstanding at a time
// ready, valid and busy to the execute stage
// bus protocol checks

`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_ex_i,    // level, held until ready_ex_o
  input  logic               gnt_i,
  input  logic               rvalid_i,
  input  lsu_mem_pkg::addr_t addr_i,      // address check only
  output logic               data_req_o,
  output logic               ready_ex_o,  // high in the grant cycle
  output logic               valid_o,     // high in the rvalid cycle
  output logic               busy_o
);

  lsu_op_pkg::lsu_state_e state_q;
  lsu_op_pkg::lsu_state_e state_d;

  ////////////////////////////////////////
  // state register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= lsu_op_pkg::IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////

  always_comb
  begin
    state_d    = state_q;
    data_req_o = 1'b0;
    ready_ex_o = 1'b0;
    valid_o    = 1'b0;

    case (state_q)
      lsu_op_pkg::IDLE:
      begin
        // forward the request in the same cycle
        if (req_ex_i)
        begin
          data_req_o = 1'b1;
          if (gnt_i)
          begin
            ready_ex_o = 1'b1;                    // accepted right away
            state_d    = lsu_op_pkg::WAIT_RVALID;
          end
          else
          begin
            state_d = lsu_op_pkg::WAIT_GNT;       // back-pressure
          end
        end
      end

      lsu_op_pkg::WAIT_GNT:
      begin
        data_req_o = 1'b1;  // execute stage holds addr and data stable
        if (gnt_i)
        begin
          ready_ex_o = 1'b1;
          state_d    = lsu_op_pkg::WAIT_RVALID;
        end
      end

      lsu_op_pkg::WAIT_RVALID:
      begin
        // request stays low, no second transfer in flight
        if (rvalid_i)
        begin
          valid_o = 1'b1;
          state_d = lsu_op_pkg::IDLE;
        end
      end

      default:
      begin
        state_d = lsu_op_pkg::IDLE;  // unused encoding
      end
    endcase
  end

  assign busy_o = data_req_o || (state_q == lsu_op_pkg::WAIT_RVALID);

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // memory may only grant again once the previous response is back
  a_no_gnt_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == lsu_op_pkg::WAIT_RVALID && gnt_i) |-> rvalid_i)
    else $error("grant while a response is pending");

  // a response with nothing outstanding
  a_no_rvalid_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == lsu_op_pkg::IDLE) |-> !rvalid_i)
    else $error("rvalid in IDLE");

  a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> !$isunknown(addr_i))
    else $error("unknown address on request");

endmodule

`default_nettype wire

// ==== logic/lsu_load_align.sv ====
// load-side alignment
// access attributes captured on grant
// byte/halfword extraction with zero or sign extension
// hold register for the last load result

`timescale 1ns/1ps
`default_nettype none

module lsu_load_align
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               gnt_i,        // transfer accepted this cycle
  input  logic               rvalid_i,     // response data valid
  input  logic               we_i,
  input  lsu_op_pkg::size_t  data_type_i,
  input  logic               sign_ext_i,
  input  lsu_mem_pkg::lane_t lane_i,
  input  lsu_mem_pkg::word_t rdata_i,      // raw memory word
  output lsu_mem_pkg::word_t rdata_o       // extended load value to the register side
);

  lsu_op_pkg::size_t  type_q;      // size of the outstanding access
  lsu_mem_pkg::lane_t lane_q;      // lane of the outstanding access
  logic               sign_ext_q;
  logic               we_q;        // outstanding access is a store
  logic               gnt_seen_q;  // any grant since reset

  logic [7:0]         byte_sel;
  logic [15:0]        half_sel;
  lsu_mem_pkg::word_t rdata_ext;
  lsu_mem_pkg::word_t rdata_q;     // last load result

  ////////////////////////////////////////
  // attribute capture
  ////////////////////////////////////////

  // execute stage moves on after the grant, so keep what the response needs
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q     <= lsu_op_pkg::SIZE_WORD;
      lane_q     <= '0;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
      gnt_seen_q <= 1'b0;
    end
    else if (gnt_i)
    begin
      type_q     <= data_type_i;
      lane_q     <= lane_i;
      sign_ext_q <= sign_ext_i;
      we_q       <= we_i;
      gnt_seen_q <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // extraction and extension
  ////////////////////////////////////////

  assign byte_sel = rdata_i[{lane_q, 3'b000} +: 8];      // any lane
  assign half_sel = rdata_i[{lane_q[1], 4'b0000} +: 16]; // aligned, lane 0 or 2

  always_comb
  begin
    case (type_q)
      lsu_op_pkg::SIZE_WORD:        rdata_ext = rdata_i;
      lsu_op_pkg::SIZE_HALF:        rdata_ext = {{16{sign_ext_q & half_sel[15]}}, half_sel};
      lsu_op_pkg::SIZE_BYTE, 2'b11: rdata_ext = {{24{sign_ext_q & byte_sel[7]}}, byte_sel};
    endcase
  end

  // hold register, only loads update it
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdata_q <= '0;
    end
    else if (rvalid_i && !we_q)
    begin
      rdata_q <= rdata_ext;
    end
  end

  // live value in the response cycle, held value otherwise
  assign rdata_o = (rvalid_i && !we_q) ? rdata_ext : rdata_q;

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // a response needs a captured set of attributes behind it
  a_rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> gnt_seen_q)
    else $error("rvalid without any prior grant");

endmodule

`default_nettype wire

// ==== logic/lsu_store_align.sv ====
// store-side alignment
// byte-enable generation from size and lane
// write-data rotation onto the addressed byte lanes
// alignment check on every request

`timescale 1ns/1ps
`default_nettype none

module lsu_store_align
(
  input  logic               clk,          // assertion clock only
  input  logic               req_i,        // assertion qualifier only
  input  lsu_op_pkg::size_t  data_type_i,
  input  lsu_mem_pkg::lane_t lane_i,       // addr[1:0]
  input  lsu_mem_pkg::word_t wdata_i,      // register value, byte 0 in [7:0]
  output lsu_mem_pkg::be_t   be_o,
  output lsu_mem_pkg::word_t wdata_o       // lane-rotated write word
);

  // enables start at the addressed lane and cover the access width
  always_comb
  begin
    case (data_type_i)
      lsu_op_pkg::SIZE_WORD:            be_o = lsu_mem_pkg::BE_ALL;
      lsu_op_pkg::SIZE_HALF:            be_o = 4'b0011 << lane_i;  // lane 0 or 2
      lsu_op_pkg::SIZE_BYTE, 2'b11:     be_o = 4'b0001 << lane_i;  // one lane
    endcase
  end

  // rotate left by lane bytes, reg byte 0 lands on the addressed lane
  always_comb
  begin
    case (lane_i)
      2'd0:    wdata_o = wdata_i;
      2'd1:    wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'd2:    wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  // no split transfers here, the execute stage must only issue aligned accesses
  a_aligned_req: assert property (@(posedge clk)
    req_i |-> ((data_type_i != lsu_op_pkg::SIZE_WORD || lane_i == 2'b00) &&
               (data_type_i != lsu_op_pkg::SIZE_HALF || lane_i[0] == 1'b0)))
    else $error("misaligned access size %0d lane %0d", data_type_i, lane_i);

endmodule

`default_nettype wire

// ==== logic/lsu_op_pkg.sv ====
// load/store operation encodings
// access size type and its constants
// controller state enum, also named by the testbench

`default_nettype none

package lsu_op_pkg;

  ////////////////////////////////////////
  // access size
  ////////////////////////////////////////

  // 2'b11 is not a legal size, the datapath handles it as a byte
  typedef logic [1:0] size_t;

  localparam size_t SIZE_WORD = 2'b00;  // 32 bit, lane 0 only
  localparam size_t SIZE_HALF = 2'b01;  // 16 bit, even lanes
  localparam size_t SIZE_BYTE = 2'b10;  // 8 bit, any lane

  ////////////////////////////////////////
  // controller FSM
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE        = 2'b00,  // no transfer, request forwarded straight through
    WAIT_GNT    = 2'b01,  // request up, memory back-pressuring
    WAIT_RVALID = 2'b10   // accepted, waiting for the response
  } lsu_state_e;

endpackage

`default_nettype wire

// ==== logic/lsu_mem_pkg.sv ====
// data-memory bus types for the load/store unit
// byte address, data word, byte enables and lane offset
// all-lanes byte-enable constant

`default_nettype none

package lsu_mem_pkg;

  ////////////////////////////////////////
  // bus field types
  ////////////////////////////////////////

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] word_t;  // one data word, four byte lanes
  typedef logic [3:0]  be_t;    // one enable per byte lane
  typedef logic [1:0]  lane_t;  // byte offset inside a word, addr[1:0]

  ////////////////////////////////////////
  // constants
  ////////////////////////////////////////

  // full-word write, every lane enabled
  localparam be_t BE_ALL = 4'b1111;

endpackage

`default_nettype wire
